// ==== hdl/cache_lru.sv ====
// ========================================
// Tree pseudo-LRU for a four-way cache.
// The read is combinational; updates land on the clock edge.
// All sets reset to zero, which makes way 0 the first victim.
// ========================================
`timescale 1ns/1ps

module cache_lru
	#(parameter SET_INDEX_WIDTH = 4,
	parameter NUM_SETS = 16)
	(input logic clk,
	input logic rst,
	input logic [SET_INDEX_WIDTH-1:0] read_set,
	input logic update,
	input logic [SET_INDEX_WIDTH-1:0] update_set,
	input logic [1:0] update_way,
	output logic [1:0] lru_way);

	// bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3.
	// each bit points toward the side that was used less recently.
	logic [2:0] tree_bits [NUM_SETS];
	logic [2:0] read_bits;
	logic [2:0] next_bits;

	assign read_bits = tree_bits[read_set];
	assign lru_way = read_bits[0] ? {1'b1, read_bits[2]} : {1'b0, read_bits[1]};

	// point the root and the touched half away from the way just used.
	always_comb
	begin
		next_bits = tree_bits[update_set];
		next_bits[0] = ~update_way[1];
		if (update_way[1])
			next_bits[2] = ~update_way[0];
		else
			next_bits[1] = ~update_way[0];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_SETS; i++)
				tree_bits[i] <= 3'b000;
		end
		else if (update)
		begin
			tree_bits[update_set] <= next_bits;
		end
	end

endmodule

// ==== hdl/l2_cache_arb.sv ====
// ========================================
// Arbitration stage. A fill restart always wins over a core request.
// A core request that loses is held in one slot and issued next.
// The fill source must hold fill_valid across stalled cycles.
// ========================================
`timescale 1ns/1ps
`include "l2_cache_defines.svh"

module l2_cache_arb
	(input logic clk,
	input logic rst,
	input logic stall,
	input logic clear_done,
	input logic core_valid,
	input logic [`L2_UNIT_WIDTH-1:0] core_unit,
	input logic [`L2_STRAND_WIDTH-1:0] core_strand,
	input l2_cache_pkg::l2_op_t core_op,
	input logic [`L2_ADDR_WIDTH-1:0] core_address,
	input logic [`L2_DATA_WIDTH-1:0] core_data,
	input logic [`L2_MASK_WIDTH-1:0] core_mask,
	input logic fill_valid,
	input logic [`L2_ADDR_WIDTH-1:0] fill_address,
	input logic [`L2_WAY_WIDTH-1:0] fill_way,
	input logic [`L2_DATA_WIDTH-1:0] fill_data,
	output logic core_ready,
	output logic arb_valid,
	output logic [`L2_UNIT_WIDTH-1:0] arb_unit,
	output logic [`L2_STRAND_WIDTH-1:0] arb_strand,
	output l2_cache_pkg::l2_op_t arb_op,
	output logic [`L2_ADDR_WIDTH-1:0] arb_address,
	output logic [`L2_DATA_WIDTH-1:0] arb_data,
	output logic [`L2_MASK_WIDTH-1:0] arb_mask,
	output logic arb_has_sm_data,
	output logic [`L2_DATA_WIDTH-1:0] arb_sm_data,
	output logic [`L2_WAY_WIDTH-1:0] arb_sm_fill_way);

	import l2_cache_pkg::*;

	arb_state_t slot_state;
	logic [`L2_UNIT_WIDTH-1:0] slot_unit;
	logic [`L2_STRAND_WIDTH-1:0] slot_strand;
	l2_op_t slot_op;
	logic [`L2_ADDR_WIDTH-1:0] slot_address;
	logic [`L2_DATA_WIDTH-1:0] slot_data;
	logic [`L2_MASK_WIDTH-1:0] slot_mask;
	logic slot_held;
	logic core_accept;
	logic load_slot;

	assign slot_held = slot_state == arb_held;
	assign core_ready = !stall && clear_done && !slot_held;
	assign core_accept = core_valid && core_ready;
	assign load_slot = fill_valid && core_accept;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			slot_state <= arb_empty;
			arb_valid <= 1'b0;
		end
		else if (!stall)
		begin
			arb_valid <= fill_valid || slot_held || core_accept;
			if (load_slot)
				slot_state <= arb_held;
			else if (!fill_valid)
				slot_state <= arb_empty;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_slot)
		begin
			slot_unit <= core_unit;
			slot_strand <= core_strand;
			slot_op <= core_op;
			slot_address <= core_address;
			slot_data <= core_data;
			slot_mask <= core_mask;
		end
	end

	// core requests carry zero in the fill fields so they compare cleanly downstream.
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			arb_has_sm_data <= fill_valid;
			arb_sm_data <= fill_valid ? fill_data : '0;
			arb_sm_fill_way <= fill_valid ? fill_way : '0;
			if (fill_valid)
			begin
				arb_unit <= '0;
				arb_strand <= '0;
				arb_op <= op_nop;
				arb_address <= fill_address;
				arb_data <= '0;
				arb_mask <= '0;
			end
			else
			begin
				arb_unit <= slot_held ? slot_unit : core_unit;
				arb_strand <= slot_held ? slot_strand : core_strand;
				arb_op <= slot_held ? slot_op : core_op;
				arb_address <= slot_held ? slot_address : core_address;
				arb_data <= slot_held ? slot_data : core_data;
				arb_mask <= slot_held ? slot_mask : core_mask;
			end
		end
	end

	// a fill offered during a stall must still be offered on the next edge.
	a_fill_held_in_stall: assert property (@(posedge clk) disable iff (rst)
		fill_valid && stall |=> fill_valid);

endmodule

// ==== hdl/l2_cache_defines.svh ====
// ========================================
// Geometry of the L2 tag pipeline.
// Addresses are line addresses and the set index is taken from the low bits.
// The way count is fixed at four because the tree LRU and the way fields are two bits.
// ========================================
`ifndef L2_CACHE_DEFINES_SVH
`define L2_CACHE_DEFINES_SVH

`define L2_NUM_WAYS 4
`define L2_WAY_WIDTH 2

`define L2_SET_INDEX_WIDTH 4
`define L2_NUM_SETS (1 << `L2_SET_INDEX_WIDTH)

`define L2_ADDR_WIDTH 26
`define L2_OFFSET_WIDTH 0
`define L2_TAG_WIDTH (`L2_ADDR_WIDTH - `L2_SET_INDEX_WIDTH)

// request payload, narrowed from the full line width.
`define L2_DATA_WIDTH 64
`define L2_MASK_WIDTH 8

`define L2_UNIT_WIDTH 2
`define L2_STRAND_WIDTH 2

`endif

// ==== hdl/l2_cache_hit.sv ====
// ========================================
// Hit stage. Compares the four tags and picks the replace way.
// The LRU update goes out as a request leaves this stage, so a
// request one or two cycles behind to the same set sees the older LRU.
// ========================================
`timescale 1ns/1ps
`include "l2_cache_defines.svh"

module l2_cache_hit
	(input logic clk,
	input logic rst,
	input logic stall,
	input logic tag_valid,
	input logic [`L2_UNIT_WIDTH-1:0] tag_unit,
	input logic [`L2_STRAND_WIDTH-1:0] tag_strand,
	input l2_cache_pkg::l2_op_t tag_op,
	input logic [`L2_ADDR_WIDTH-1:0] tag_address,
	input logic [`L2_DATA_WIDTH-1:0] tag_data,
	input logic [`L2_MASK_WIDTH-1:0] tag_mask,
	input logic tag_has_sm_data,
	input logic [`L2_DATA_WIDTH-1:0] tag_sm_data,
	input logic [`L2_WAY_WIDTH-1:0] tag_sm_fill_way,
	input logic [`L2_WAY_WIDTH-1:0] tag_lru_way,
	input logic [`L2_TAG_WIDTH-1:0] tag_tag0,
	input logic [`L2_TAG_WIDTH-1:0] tag_tag1,
	input logic [`L2_TAG_WIDTH-1:0] tag_tag2,
	input logic [`L2_TAG_WIDTH-1:0] tag_tag3,
	input logic tag_valid0,
	input logic tag_valid1,
	input logic tag_valid2,
	input logic tag_valid3,
	output logic hit_valid,
	output logic [`L2_UNIT_WIDTH-1:0] hit_unit,
	output logic [`L2_STRAND_WIDTH-1:0] hit_strand,
	output l2_cache_pkg::l2_op_t hit_op,
	output logic [`L2_ADDR_WIDTH-1:0] hit_address,
	output logic [`L2_DATA_WIDTH-1:0] hit_data,
	output logic [`L2_MASK_WIDTH-1:0] hit_mask,
	output logic hit_has_sm_data,
	output logic [`L2_DATA_WIDTH-1:0] hit_sm_data,
	output logic [`L2_WAY_WIDTH-1:0] hit_sm_fill_way,
	output logic hit_hit,
	output logic [`L2_WAY_WIDTH-1:0] hit_hit_way,
	output logic [`L2_WAY_WIDTH-1:0] hit_replace_way,
	output logic mru_update,
	output logic [`L2_SET_INDEX_WIDTH-1:0] mru_set,
	output logic [`L2_WAY_WIDTH-1:0] mru_way);

	import l2_cache_pkg::*;

	logic [`L2_TAG_WIDTH-1:0] req_tag;
	logic [`L2_NUM_WAYS-1:0] way_match;
	logic [`L2_WAY_WIDTH-1:0] match_way;
	logic [`L2_WAY_WIDTH-1:0] replace_way;

	assign req_tag = tag_address[`L2_ADDR_WIDTH-1 -: `L2_TAG_WIDTH];
	assign way_match[0] = tag_valid0 && tag_tag0 == req_tag;
	assign way_match[1] = tag_valid1 && tag_tag1 == req_tag;
	assign way_match[2] = tag_valid2 && tag_tag2 == req_tag;
	assign way_match[3] = tag_valid3 && tag_tag3 == req_tag;

	// one-hot to binary, correct only while at most one way matches.
	assign match_way = {way_match[3] | way_match[2], way_match[3] | way_match[1]};

	always_comb
	begin
		if (!tag_valid0)
			replace_way = 2'd0;
		else if (!tag_valid1)
			replace_way = 2'd1;
		else if (!tag_valid2)
			replace_way = 2'd2;
		else if (!tag_valid3)
			replace_way = 2'd3;
		else
			replace_way = tag_lru_way;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			hit_valid <= 1'b0;
		else if (!stall)
			hit_valid <= tag_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			hit_unit <= tag_unit;
			hit_strand <= tag_strand;
			hit_op <= tag_op;
			hit_address <= tag_address;
			hit_data <= tag_data;
			hit_mask <= tag_mask;
			hit_has_sm_data <= tag_has_sm_data;
			hit_sm_data <= tag_sm_data;
			hit_sm_fill_way <= tag_sm_fill_way;
			hit_hit <= |way_match;
			hit_hit_way <= match_way;
			hit_replace_way <= replace_way;
		end
	end

	assign mru_update = hit_valid && !stall && hit_op != op_nop
		&& (hit_hit || hit_has_sm_data);
	assign mru_set = hit_address[`L2_OFFSET_WIDTH +: `L2_SET_INDEX_WIDTH];
	assign mru_way = hit_has_sm_data ? hit_sm_fill_way : hit_hit_way;

	// holds only as long as fills never place a tag that is already resident in the set.
	a_one_way_match: assert property (@(posedge clk) disable iff (rst)
		tag_valid |-> $onehot0(way_match));

endmodule

// ==== hdl/l2_cache_pkg.sv ====
// ========================================
// Types shared by the L2 tag pipeline stages.
// The opcode only matters to the tag side in that op_nop never moves the LRU.
// ========================================
package l2_cache_pkg;

	// request opcodes, carried through every stage.
	typedef enum logic [2:0]
	{
		op_load = 3'd0,
		op_store = 3'd1,
		op_nop = 3'd2
	} l2_op_t;

	// state of the one-entry slot for a core request displaced by a fill.
	typedef enum logic
	{
		arb_empty = 1'b0,
		arb_held = 1'b1
	} arb_state_t;

endpackage

// ==== hdl/l2_cache_tag.sv ====
// ========================================
// Tag stage. Reads all four ways and the LRU for the request's set.
// A fill writes its tag on the same edge it reads, so the next request sees it.
// After reset the valid bits are cleared one set per cycle until reset_done.
// ========================================
`timescale 1ns/1ps
`include "l2_cache_defines.svh"

module l2_cache_tag
	(input logic clk,
	input logic rst,
	input logic stall,
	input logic arb_valid,
	input logic [`L2_UNIT_WIDTH-1:0] arb_unit,
	input logic [`L2_STRAND_WIDTH-1:0] arb_strand,
	input l2_cache_pkg::l2_op_t arb_op,
	input logic [`L2_ADDR_WIDTH-1:0] arb_address,
	input logic [`L2_DATA_WIDTH-1:0] arb_data,
	input logic [`L2_MASK_WIDTH-1:0] arb_mask,
	input logic arb_has_sm_data,
	input logic [`L2_DATA_WIDTH-1:0] arb_sm_data,
	input logic [`L2_WAY_WIDTH-1:0] arb_sm_fill_way,
	input logic mru_update,
	input logic [`L2_SET_INDEX_WIDTH-1:0] mru_set,
	input logic [`L2_WAY_WIDTH-1:0] mru_way,
	output logic tag_valid,
	output logic [`L2_UNIT_WIDTH-1:0] tag_unit,
	output logic [`L2_STRAND_WIDTH-1:0] tag_strand,
	output l2_cache_pkg::l2_op_t tag_op,
	output logic [`L2_ADDR_WIDTH-1:0] tag_address,
	output logic [`L2_DATA_WIDTH-1:0] tag_data,
	output logic [`L2_MASK_WIDTH-1:0] tag_mask,
	output logic tag_has_sm_data,
	output logic [`L2_DATA_WIDTH-1:0] tag_sm_data,
	output logic [`L2_WAY_WIDTH-1:0] tag_sm_fill_way,
	output logic [`L2_WAY_WIDTH-1:0] tag_lru_way,
	output logic [`L2_TAG_WIDTH-1:0] tag_tag0,
	output logic [`L2_TAG_WIDTH-1:0] tag_tag1,
	output logic [`L2_TAG_WIDTH-1:0] tag_tag2,
	output logic [`L2_TAG_WIDTH-1:0] tag_tag3,
	output logic tag_valid0,
	output logic tag_valid1,
	output logic tag_valid2,
	output logic tag_valid3,
	output logic reset_done);

	logic [`L2_TAG_WIDTH-1:0] tag_mem [`L2_NUM_WAYS][`L2_NUM_SETS];
	logic valid_mem [`L2_NUM_WAYS][`L2_NUM_SETS];
	logic [`L2_SET_INDEX_WIDTH-1:0] read_set;
	logic [`L2_TAG_WIDTH-1:0] read_tag;
	logic [`L2_SET_INDEX_WIDTH-1:0] clear_set;
	logic [`L2_WAY_WIDTH-1:0] lru_way;
	logic fill_write;

	assign read_set = arb_address[`L2_OFFSET_WIDTH +: `L2_SET_INDEX_WIDTH];
	assign read_tag = arb_address[`L2_ADDR_WIDTH-1 -: `L2_TAG_WIDTH];
	assign fill_write = !stall && arb_valid && arb_has_sm_data;

	cache_lru #(
		.SET_INDEX_WIDTH(`L2_SET_INDEX_WIDTH),
		.NUM_SETS(`L2_NUM_SETS)) lru_i
	(
		.clk(clk),
		.rst(rst),
		.read_set(read_set),
		.update(mru_update),
		.update_set(mru_set),
		.update_way(mru_way),
		.lru_way(lru_way)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clear_set <= '0;
			reset_done <= 1'b0;
		end
		else if (!reset_done)
		begin
			clear_set <= clear_set + 1'b1;
			if (&clear_set)
				reset_done <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset_done)
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
				valid_mem[w][clear_set] <= 1'b0;
		end
		else if (fill_write)
		begin
			valid_mem[arb_sm_fill_way][read_set] <= 1'b1;
			tag_mem[arb_sm_fill_way][read_set] <= read_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			tag_valid <= 1'b0;
		else if (!stall)
			tag_valid <= arb_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			tag_unit <= arb_unit;
			tag_strand <= arb_strand;
			tag_op <= arb_op;
			tag_address <= arb_address;
			tag_data <= arb_data;
			tag_mask <= arb_mask;
			tag_has_sm_data <= arb_has_sm_data;
			tag_sm_data <= arb_sm_data;
			tag_sm_fill_way <= arb_sm_fill_way;
			tag_lru_way <= lru_way;
			tag_tag0 <= tag_mem[0][read_set];
			tag_tag1 <= tag_mem[1][read_set];
			tag_tag2 <= tag_mem[2][read_set];
			tag_tag3 <= tag_mem[3][read_set];
			tag_valid0 <= valid_mem[0][read_set];
			tag_valid1 <= valid_mem[1][read_set];
			tag_valid2 <= valid_mem[2][read_set];
			tag_valid3 <= valid_mem[3][read_set];
		end
	end

	// the clear pass would wipe out a fill that landed before it finished.
	a_fill_after_clear: assert property (@(posedge clk) disable iff (rst)
		arb_valid && arb_has_sm_data |-> reset_done);

endmodule

// ==== hdl/l2_cache_tag_pipe.sv ====
// ========================================
// L2 tag pipeline, arbitration then tag read then hit compare.
// Results appear three cycles after acceptance plus one per stalled cycle.
// ========================================
`timescale 1ns/1ps
`include "l2_cache_defines.svh"

module l2_cache_tag_pipe
	(input logic clk,
	input logic rst,
	input logic stall,
	input logic core_valid,
	input logic [`L2_UNIT_WIDTH-1:0] core_unit,
	input logic [`L2_STRAND_WIDTH-1:0] core_strand,
	input l2_cache_pkg::l2_op_t core_op,
	input logic [`L2_ADDR_WIDTH-1:0] core_address,
	input logic [`L2_DATA_WIDTH-1:0] core_data,
	input logic [`L2_MASK_WIDTH-1:0] core_mask,
	input logic fill_valid,
	input logic [`L2_ADDR_WIDTH-1:0] fill_address,
	input logic [`L2_WAY_WIDTH-1:0] fill_way,
	input logic [`L2_DATA_WIDTH-1:0] fill_data,
	output logic core_ready,
	output logic hit_valid,
	output logic [`L2_UNIT_WIDTH-1:0] hit_unit,
	output logic [`L2_STRAND_WIDTH-1:0] hit_strand,
	output l2_cache_pkg::l2_op_t hit_op,
	output logic [`L2_ADDR_WIDTH-1:0] hit_address,
	output logic [`L2_DATA_WIDTH-1:0] hit_data,
	output logic [`L2_MASK_WIDTH-1:0] hit_mask,
	output logic hit_has_sm_data,
	output logic [`L2_DATA_WIDTH-1:0] hit_sm_data,
	output logic [`L2_WAY_WIDTH-1:0] hit_sm_fill_way,
	output logic hit_hit,
	output logic [`L2_WAY_WIDTH-1:0] hit_hit_way,
	output logic [`L2_WAY_WIDTH-1:0] hit_replace_way);

	import l2_cache_pkg::*;

	logic arb_valid;
	logic [`L2_UNIT_WIDTH-1:0] arb_unit;
	logic [`L2_STRAND_WIDTH-1:0] arb_strand;
	l2_op_t arb_op;
	logic [`L2_ADDR_WIDTH-1:0] arb_address;
	logic [`L2_DATA_WIDTH-1:0] arb_data;
	logic [`L2_MASK_WIDTH-1:0] arb_mask;
	logic arb_has_sm_data;
	logic [`L2_DATA_WIDTH-1:0] arb_sm_data;
	logic [`L2_WAY_WIDTH-1:0] arb_sm_fill_way;

	logic tag_valid;
	logic [`L2_UNIT_WIDTH-1:0] tag_unit;
	logic [`L2_STRAND_WIDTH-1:0] tag_strand;
	l2_op_t tag_op;
	logic [`L2_ADDR_WIDTH-1:0] tag_address;
	logic [`L2_DATA_WIDTH-1:0] tag_data;
	logic [`L2_MASK_WIDTH-1:0] tag_mask;
	logic tag_has_sm_data;
	logic [`L2_DATA_WIDTH-1:0] tag_sm_data;
	logic [`L2_WAY_WIDTH-1:0] tag_sm_fill_way;
	logic [`L2_WAY_WIDTH-1:0] tag_lru_way;
	logic [`L2_TAG_WIDTH-1:0] tag_tag0;
	logic [`L2_TAG_WIDTH-1:0] tag_tag1;
	logic [`L2_TAG_WIDTH-1:0] tag_tag2;
	logic [`L2_TAG_WIDTH-1:0] tag_tag3;
	logic tag_valid0;
	logic tag_valid1;
	logic tag_valid2;
	logic tag_valid3;

	logic mru_update;
	logic [`L2_SET_INDEX_WIDTH-1:0] mru_set;
	logic [`L2_WAY_WIDTH-1:0] mru_way;
	logic reset_done;

	// stage ports share their names with these nets.
	l2_cache_arb arb_i
	(
		.*,
		.clear_done(reset_done)
	);

	l2_cache_tag tag_i
	(
		.*
	);

	l2_cache_hit hit_i
	(
		.*
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Compiles the tag pipeline testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_l2_cache -o tb_l2_cache \
	-f vlog.f

./obj_dir/tb_l2_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== test/l2_tag_model.svh ====
// ========================================
// Reference model of the tag side, updated in request order at acceptance.
// Fills carry op_nop and therefore never move the LRU.
// Must be included inside a module that imports l2_cache_pkg.
// ========================================
`ifndef L2_TAG_MODEL_SVH
`define L2_TAG_MODEL_SVH

typedef struct packed
{
	logic [`L2_UNIT_WIDTH-1:0] unit;
	logic [`L2_STRAND_WIDTH-1:0] strand;
	l2_op_t op;
	logic [`L2_ADDR_WIDTH-1:0] address;
	logic [`L2_DATA_WIDTH-1:0] data;
	logic [`L2_MASK_WIDTH-1:0] mask;
	logic has_sm_data;
	logic [`L2_DATA_WIDTH-1:0] sm_data;
	logic [`L2_WAY_WIDTH-1:0] sm_fill_way;
	logic hit;
	logic [`L2_WAY_WIDTH-1:0] hit_way;
	logic [`L2_WAY_WIDTH-1:0] replace_way;
	logic check_replace;
} result_t;

logic [`L2_TAG_WIDTH-1:0] ref_tag [`L2_NUM_WAYS][`L2_NUM_SETS];
logic ref_valid [`L2_NUM_WAYS][`L2_NUM_SETS];
logic [2:0] ref_lru [`L2_NUM_SETS];
result_t exp_q [$];

function automatic void clear_model();
	for (int s = 0; s < `L2_NUM_SETS; s++)
	begin
		ref_lru[s] = 3'b000;
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			ref_valid[w][s] = 1'b0;
	end
	exp_q.delete();
endfunction

// the root picks a half, the leaf bit of that half picks the way.
function automatic logic [1:0] lru_victim(int s);
	if (ref_lru[s][0])
		return ref_lru[s][2] ? 2'd3 : 2'd2;
	return ref_lru[s][1] ? 2'd1 : 2'd0;
endfunction

// every bit on the path is turned to point away from the way just used.
function automatic void mark_used(int s, logic [1:0] way);
	if (way < 2'd2)
	begin
		ref_lru[s][0] = 1'b1;
		ref_lru[s][1] = (way == 2'd0);
	end
	else
	begin
		ref_lru[s][0] = 1'b0;
		ref_lru[s][2] = (way == 2'd2);
	end
endfunction

function automatic bit tag_resident(int s, logic [`L2_TAG_WIDTH-1:0] t);
	for (int w = 0; w < `L2_NUM_WAYS; w++)
		if (ref_valid[w][s] && ref_tag[w][s] == t)
			return 1'b1;
	return 1'b0;
endfunction

// a fill looks up the old contents of the set, then writes its way.
function automatic void enqueue_request(result_t r, bit settled);
	int s;
	logic [`L2_TAG_WIDTH-1:0] t;
	bit any_invalid;
	s = int'(r.address[`L2_SET_INDEX_WIDTH-1:0]);
	t = r.address[`L2_ADDR_WIDTH-1 -: `L2_TAG_WIDTH];
	r.hit = 1'b0;
	r.hit_way = 2'd0;
	r.replace_way = 2'd0;
	any_invalid = 1'b0;
	for (int w = 0; w < `L2_NUM_WAYS; w++)
		if (ref_valid[w][s] && ref_tag[w][s] == t)
		begin
			r.hit = 1'b1;
			r.hit_way = 2'(w);
		end
	for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
		if (!ref_valid[w][s])
		begin
			r.replace_way = 2'(w);
			any_invalid = 1'b1;
		end
	if (!any_invalid)
		r.replace_way = lru_victim(s);
	r.check_replace = any_invalid || settled;
	if (r.has_sm_data)
	begin
		ref_tag[r.sm_fill_way][s] = t;
		ref_valid[r.sm_fill_way][s] = 1'b1;
	end
	if (r.op != op_nop && (r.hit || r.has_sm_data))
		mark_used(s, r.has_sm_data ? r.sm_fill_way : r.hit_way);
	exp_q.push_back(r);
endfunction

`endif

// ==== test/tb_l2_cache.sv ====
// ========================================
// Testbench for the L2 tag pipeline with random traffic from seed 44.
// The replace way is checked against the LRU only for requests that
// follow three or more idle cycles.
// ========================================
`timescale 1ns/1ps
`include "l2_cache_defines.svh"

module tb_l2_cache;

	import l2_cache_pkg::*;

	localparam int AW = `L2_ADDR_WIDTH;
	localparam int TW = `L2_TAG_WIDTH;
	localparam int SW = `L2_SET_INDEX_WIDTH;
	localparam int RANDOM_REQS = 300;
	localparam int STALL_REQS = 300;
	localparam int REPLACE_REQS = 120;
	localparam int DIRECTED_REQS = 8;
	localparam int TOTAL_REQS = RANDOM_REQS + STALL_REQS + REPLACE_REQS + DIRECTED_REQS;
	localparam longint WATCHDOG_NS = 20 * TOTAL_REQS * 10;

	logic clk;
	logic rst;
	logic stall;
	logic core_valid;
	logic [`L2_UNIT_WIDTH-1:0] core_unit;
	logic [`L2_STRAND_WIDTH-1:0] core_strand;
	l2_op_t core_op;
	logic [AW-1:0] core_address;
	logic [`L2_DATA_WIDTH-1:0] core_data;
	logic [`L2_MASK_WIDTH-1:0] core_mask;
	logic fill_valid;
	logic [AW-1:0] fill_address;
	logic [`L2_WAY_WIDTH-1:0] fill_way;
	logic [`L2_DATA_WIDTH-1:0] fill_data;
	logic core_ready;
	logic hit_valid;
	logic [`L2_UNIT_WIDTH-1:0] hit_unit;
	logic [`L2_STRAND_WIDTH-1:0] hit_strand;
	l2_op_t hit_op;
	logic [AW-1:0] hit_address;
	logic [`L2_DATA_WIDTH-1:0] hit_data;
	logic [`L2_MASK_WIDTH-1:0] hit_mask;
	logic hit_has_sm_data;
	logic [`L2_DATA_WIDTH-1:0] hit_sm_data;
	logic [`L2_WAY_WIDTH-1:0] hit_sm_fill_way;
	logic hit_hit;
	logic [`L2_WAY_WIDTH-1:0] hit_hit_way;
	logic [`L2_WAY_WIDTH-1:0] hit_replace_way;

	int errors = 0;
	int test_errors = 0;
	int test_num = 0;
	int checked = 0;
	int accepted = 0;
	int idle_cycles = 0;
	int pool_size = 3;
	int set_limit = 15;
	bit pending_slot = 1'b0;

	`include "l2_tag_model.svh"

	l2_cache_tag_pipe dut_i (.*);

	always #5 clk = ~clk;

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all requests came out of the pipeline");
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
		assert (expected === actual)
		else
		begin
			$display("** Error %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// a result leaves the hit stage on the next edge when stall is low.
	always @(negedge clk)
	begin
		result_t e;
		if (!rst && stall)
		begin
			assert (!core_ready)
			else
			begin
				$display("core_ready was high while stall was high");
				errors++;
			end
		end
		if (!rst && hit_valid && !stall)
		begin
			if (exp_q.size() == 0)
			begin
				$display("result for address %h came out with no request outstanding",
					hit_address);
				errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				checked++;
				check_value("hit_unit", 64'(e.unit), 64'(hit_unit));
				check_value("hit_strand", 64'(e.strand), 64'(hit_strand));
				check_value("hit_op", 64'(e.op), 64'(hit_op));
				check_value("hit_address", 64'(e.address), 64'(hit_address));
				check_value("hit_data", e.data, hit_data);
				check_value("hit_mask", 64'(e.mask), 64'(hit_mask));
				check_value("hit_has_sm_data", 64'(e.has_sm_data), 64'(hit_has_sm_data));
				check_value("hit_sm_data", e.sm_data, hit_sm_data);
				check_value("hit_sm_fill_way", 64'(e.sm_fill_way), 64'(hit_sm_fill_way));
				check_value("hit_hit", 64'(e.hit), 64'(hit_hit));
				check_value("hit_hit_way", 64'(e.hit_way), 64'(hit_hit_way));
				if (e.check_replace)
					check_value("hit_replace_way", 64'(e.replace_way), 64'(hit_replace_way));
			end
		end
	end

	function automatic logic [AW-1:0] pool_address(int s, int idx);
		logic [TW-1:0] t;
		t = TW'(32'h2b400 + idx * 32'h0c71 + s);
		return {t, SW'(s)};
	endfunction

	task automatic pick_core();
		core_valid = 1'b1;
		core_unit = 2'($urandom_range(0, 3));
		core_strand = 2'($urandom_range(0, 3));
		core_op = l2_op_t'(3'($urandom_range(0, 2)));
		core_address = pool_address($urandom_range(0, set_limit),
			$urandom_range(0, pool_size - 1));
		core_data = {$urandom(), $urandom()};
		core_mask = 8'($urandom_range(0, 255));
	endtask

	// a fill never brings in a tag that is already resident in its set.
	task automatic pick_fill();
		logic [AW-1:0] a;
		int s;
		s = $urandom_range(0, set_limit);
		a = pool_address(s, $urandom_range(0, pool_size - 1));
		if (!tag_resident(s, a[AW-1 -: TW]))
		begin
			fill_valid = 1'b1;
			fill_address = a;
			fill_way = 2'($urandom_range(0, 3));
			fill_data = {$urandom(), $urandom()};
		end
	endtask

	// inputs are set 1 ns after the edge; acceptance is decided just before the next one.
	task automatic step();
		result_t r;
		bit core_acc;
		bit fill_acc;
		bit slot_issue;
		#8;
		fill_acc = fill_valid && !stall;
		core_acc = core_valid && core_ready;
		slot_issue = pending_slot && !stall;
		if (pending_slot)
		begin
			assert (!core_ready)
			else
			begin
				$display("core_ready was high while a displaced core request was held");
				errors++;
			end
		end
		if (slot_issue)
			pending_slot = 1'b0;
		if (fill_acc)
		begin
			r = '0;
			r.op = op_nop;
			r.address = fill_address;
			r.has_sm_data = 1'b1;
			r.sm_data = fill_data;
			r.sm_fill_way = fill_way;
			enqueue_request(r, 1'b0);
		end
		if (core_acc)
		begin
			r = '0;
			r.unit = core_unit;
			r.strand = core_strand;
			r.op = core_op;
			r.address = core_address;
			r.data = core_data;
			r.mask = core_mask;
			enqueue_request(r, idle_cycles >= 3 && !fill_acc);
		end
		if (fill_acc && core_acc)
			pending_slot = 1'b1;
		if (fill_acc || core_acc || slot_issue)
			idle_cycles = 0;
		else if (!stall)
			idle_cycles++;
		@(posedge clk);
		#1;
		if (core_acc)
			core_valid = 1'b0;
		if (fill_acc)
			fill_valid = 1'b0;
		accepted += int'(core_acc) + int'(fill_acc);
	endtask

	task automatic drain();
		stall = 1'b0;
		while (exp_q.size() != 0 || pending_slot)
			step();
	endtask

	// a fill that is still offered keeps the loop going until it is taken.
	task automatic run_traffic(int n, int stall_pct, int fill_pct, int gap);
		int target;
		target = accepted + n;
		while (accepted < target || fill_valid)
		begin
			stall = ($urandom_range(0, 99) < stall_pct);
			if (!core_valid && idle_cycles >= gap && $urandom_range(0, 99) < 70)
				pick_core();
			if (!fill_valid && !pending_slot && idle_cycles >= gap
				&& $urandom_range(0, 99) < fill_pct)
				pick_fill();
			step();
		end
		core_valid = 1'b0;
		drain();
	endtask

	task automatic start_test();
		test_num++;
		test_errors = errors;
	endtask

	task automatic report_test(string name);
		$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
	endtask

	initial
	begin
		void'($urandom(44));
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		core_valid = 1'b0;
		core_unit = '0;
		core_strand = '0;
		core_op = op_load;
		core_address = '0;
		core_data = '0;
		core_mask = '0;
		fill_valid = 1'b0;
		fill_address = '0;
		fill_way = '0;
		fill_data = '0;
		clear_model();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!core_ready)
		begin
			@(posedge clk);
			#1;
		end

		start_test();
		pick_core();
		core_op = op_load;
		core_address = pool_address(5, 0);
		while (core_valid)
			step();
		fill_valid = 1'b1;
		fill_address = pool_address(5, 0);
		fill_way = 2'd0;
		fill_data = {$urandom(), $urandom()};
		while (fill_valid)
			step();
		drain();
		pick_core();
		core_op = op_load;
		core_address = pool_address(5, 0);
		while (core_valid)
			step();
		drain();
		report_test("cold miss then fill then hit");

		start_test();
		run_traffic(RANDOM_REQS, 0, 30, 0);
		report_test("request order and field transport");

		// five tags per set always leave one that is not resident.
		start_test();
		pool_size = 5;
		repeat (3) step();
		pick_core();
		while (!fill_valid)
			pick_fill();
		step();
		assert (pending_slot)
		else
		begin
			$display("a fill and a core request in one cycle did not hold the core request");
			errors++;
		end
		step();
		assert (core_ready)
		else
		begin
			$display("core_ready stayed low after the held core request was issued");
			errors++;
		end
		drain();
		pool_size = 3;
		report_test("fill priority");

		start_test();
		run_traffic(STALL_REQS, 30, 30, 0);
		report_test("random stall");

		start_test();
		pool_size = 5;
		set_limit = 3;
		run_traffic(REPLACE_REQS, 0, 50, 3);
		report_test("replace way");

		$display("tests %0d, results checked %0d, errors %0d", test_num, checked, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
+incdir+test
hdl/l2_cache_pkg.sv
hdl/cache_lru.sv
hdl/l2_cache_arb.sv
hdl/l2_cache_tag.sv
hdl/l2_cache_hit.sv
hdl/l2_cache_tag_pipe.sv
test/tb_l2_cache.sv
